// File: source/ooo_pkg.sv
package ooo_pkg;

    localparam int rob_depth = 16;
    localparam int tag_w     = 4;
    localparam int reg_w     = 5;
    localparam int reg_count = 32;
    localparam int data_w    = 32;
    localparam int addr_w    = 32;

    typedef logic [tag_w-1:0]          tag_t;
    typedef logic [reg_w-1:0]          reg_idx_t;
    typedef logic [data_w-1:0]         data_t;
    typedef logic [addr_w-1:0]         addr_t;
    typedef logic [$clog2(rob_depth):0] count_t; // 0..rob_depth

    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        logic     is_store;
        logic     pred_taken;
    } alloc_req_t;

    typedef struct packed {
        logic  valid;
        tag_t  tag;
        data_t data;
        logic  taken;  // resolved branch direction
        addr_t target;
    } wb_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t rd;   // 0 for stores
        tag_t     tag;
        data_t    data;
    } commit_t;

    typedef struct packed {
        logic valid;
        tag_t tag;
    } store_rel_t;

    typedef struct packed {
        logic  valid;
        addr_t pc;
    } redirect_t;

    typedef struct packed {
        logic  ready;
        tag_t  tag;
        data_t value;
    } operand_t;

endpackage

// File: source/arch_regfile.sv
module arch_regfile (
    input  logic              clk,
    input  logic              rst,
    input  ooo_pkg::commit_t  commit,
    input  ooo_pkg::reg_idx_t rs1,
    input  ooo_pkg::reg_idx_t rs2,
    output ooo_pkg::data_t    rd1,
    output ooo_pkg::data_t    rd2
);

    // x0 has no storage
    ooo_pkg::data_t regs [1:ooo_pkg::reg_count-1];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < ooo_pkg::reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (commit.valid && commit.rd != '0) begin
            regs[commit.rd] <= commit.data;
        end
    end

    // no write bypass, the rob forwards until the write lands
    always_comb begin
        rd1 = '0;
        rd2 = '0;
        if (rs1 != '0) begin
            rd1 = regs[rs1];
        end
        if (rs2 != '0) begin
            rd2 = regs[rs2];
        end
    end

endmodule

// File: source/rename_table.sv
module rename_table (
    input  logic              clk,
    input  logic              rst,
    input  logic              accept,
    input  ooo_pkg::reg_idx_t accept_rd,
    input  ooo_pkg::tag_t     accept_tag,
    input  ooo_pkg::commit_t  commit,
    input  logic              flush,
    input  ooo_pkg::reg_idx_t rs1,
    input  ooo_pkg::reg_idx_t rs2,
    output logic              busy1,
    output logic              busy2,
    output ooo_pkg::tag_t     tag1,
    output ooo_pkg::tag_t     tag2
);

    logic [ooo_pkg::reg_count-1:0] busy;
    ooo_pkg::tag_t                 producer [ooo_pkg::reg_count];

    logic commit_match;

    // only the latest producer may release the register
    assign commit_match = commit.valid && commit.rd != '0 &&
                          producer[commit.rd] == commit.tag;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            busy <= '0;
        end else begin
            if (commit_match) begin
                busy[commit.rd] <= 1'b0;
            end
            // later assignment, so allocation wins on the same rd
            if (accept && accept_rd != '0) begin
                busy[accept_rd] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept && accept_rd != '0) begin
            producer[accept_rd] <= accept_tag;
        end
    end

    assign busy1 = busy[rs1];
    assign busy2 = busy[rs2];
    assign tag1  = producer[rs1];
    assign tag2  = producer[rs2];

endmodule

// File: source/reorder_buffer.sv
module reorder_buffer (
    input  logic                 clk,
    input  logic                 rst,
    input  ooo_pkg::alloc_req_t  alloc,
    output ooo_pkg::tag_t        alloc_tag,
    output logic                 alloc_full,
    output logic                 accept,
    input  ooo_pkg::wb_t         wb,
    input  logic                 store_ack,
    input  ooo_pkg::tag_t        store_ack_tag,
    output ooo_pkg::store_rel_t  store_rel,
    output ooo_pkg::commit_t     commit,
    output ooo_pkg::redirect_t   redirect,
    output logic                 flush,
    input  ooo_pkg::tag_t        q1_tag,
    input  ooo_pkg::tag_t        q2_tag,
    output logic                 q1_done,
    output logic                 q2_done,
    output ooo_pkg::data_t       q1_value,
    output ooo_pkg::data_t       q2_value
);

    // per-entry control bits
    logic [ooo_pkg::rob_depth-1:0] occupied;
    logic [ooo_pkg::rob_depth-1:0] done;
    logic [ooo_pkg::rob_depth-1:0] store_released;

    // per-entry payload
    logic [ooo_pkg::rob_depth-1:0] is_store;
    logic [ooo_pkg::rob_depth-1:0] pred_taken;
    logic [ooo_pkg::rob_depth-1:0] taken;
    ooo_pkg::reg_idx_t             rd_q     [ooo_pkg::rob_depth];
    ooo_pkg::data_t                data_q   [ooo_pkg::rob_depth];
    ooo_pkg::addr_t                target_q [ooo_pkg::rob_depth];

    ooo_pkg::tag_t   head;
    ooo_pkg::tag_t   tail;
    ooo_pkg::count_t count;

    logic head_valid;
    logic head_release;
    logic head_retire;

    function automatic ooo_pkg::tag_t next_ptr(input ooo_pkg::tag_t p);
        return (p == ooo_pkg::tag_t'(ooo_pkg::rob_depth - 1)) ? '0 : p + 1'b1;
    endfunction

    assign alloc_tag  = tail;
    assign alloc_full = (count == ooo_pkg::count_t'(ooo_pkg::rob_depth));
    assign accept     = alloc.valid && !alloc_full && !flush;

    assign head_valid   = occupied[head];
    assign head_release = head_valid && is_store[head] && !store_released[head];
    assign head_retire  = head_valid && done[head] && !head_release;
    // mispredict at head, stores carry no branch outcome
    assign flush        = head_retire && !is_store[head] &&
                          (taken[head] != pred_taken[head]);

    always_ff @(posedge clk) begin
        if (rst) begin
            head            <= '0;
            tail            <= '0;
            count           <= '0;
            occupied        <= '0;
            done            <= '0;
            store_released  <= '0;
            commit.valid    <= 1'b0;
            store_rel.valid <= 1'b0;
            redirect.valid  <= 1'b0;
        end else begin
            commit.valid    <= head_retire;
            store_rel.valid <= head_release;
            redirect.valid  <= flush;
            if (flush) begin
                head           <= '0;
                tail           <= '0;
                count          <= '0;
                occupied       <= '0;
                done           <= '0;
                store_released <= '0;
            end else begin
                if (accept) begin
                    occupied[tail]       <= 1'b1;
                    done[tail]           <= 1'b0;
                    store_released[tail] <= 1'b0;
                    tail                 <= next_ptr(tail);
                end
                if (wb.valid) begin
                    done[wb.tag] <= 1'b1;
                end
                if (store_ack) begin
                    done[store_ack_tag] <= 1'b1;
                end
                if (head_release) begin
                    store_released[head] <= 1'b1;
                end
                // done stays set so the value forwards until the rf write
                if (head_retire) begin
                    occupied[head] <= 1'b0;
                    head           <= next_ptr(head);
                end
                count <= count + ooo_pkg::count_t'(accept)
                               - ooo_pkg::count_t'(head_retire);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            rd_q[tail]       <= alloc.rd;
            is_store[tail]   <= alloc.is_store;
            pred_taken[tail] <= alloc.pred_taken;
            data_q[tail]     <= '0;
        end
        if (wb.valid) begin
            data_q[wb.tag]   <= wb.data;
            taken[wb.tag]    <= wb.taken;
            target_q[wb.tag] <= wb.target;
        end
    end

    // head snapshot, qualified by the valids above
    always_ff @(posedge clk) begin
        commit.rd     <= is_store[head] ? '0 : rd_q[head];
        commit.tag    <= head;
        commit.data   <= data_q[head];
        store_rel.tag <= head;
        redirect.pc   <= target_q[head];
    end

    assign q1_done  = done[q1_tag];
    assign q2_done  = done[q2_tag];
    assign q1_value = data_q[q1_tag];
    assign q2_value = data_q[q2_tag];

endmodule

// File: source/operand_resolve.sv
module operand_resolve (
    input  logic              busy,
    input  ooo_pkg::tag_t     tag,
    input  ooo_pkg::data_t    rf_value,
    input  logic              rob_done,
    input  ooo_pkg::data_t    rob_value,
    output ooo_pkg::operand_t op
);

    always_comb begin
        op.ready = 1'b1;
        op.tag   = '0;
        op.value = rf_value;
        if (busy) begin
            if (rob_done) begin
                op.value = rob_value; // forwarded, not yet in the rf
            end else begin
                op.ready = 1'b0;
                op.tag   = tag;
                op.value = '0;
            end
        end
    end

endmodule

// File: source/ooo_backend.sv
module ooo_backend (
    input  logic                 clk,
    input  logic                 rst,
    input  ooo_pkg::alloc_req_t  alloc,
    input  ooo_pkg::reg_idx_t    rs1,
    input  ooo_pkg::reg_idx_t    rs2,
    input  ooo_pkg::wb_t         wb,
    input  logic                 store_ack,
    input  ooo_pkg::tag_t        store_ack_tag,
    output ooo_pkg::tag_t        alloc_tag,
    output logic                 alloc_full,
    output ooo_pkg::operand_t    op1,
    output ooo_pkg::operand_t    op2,
    output ooo_pkg::commit_t     commit,
    output ooo_pkg::store_rel_t  store_rel,
    output ooo_pkg::redirect_t   redirect
);

    logic              accept;
    logic              flush;
    ooo_pkg::reg_idx_t accept_rd;
    ooo_pkg::data_t    rf1;
    ooo_pkg::data_t    rf2;
    logic              busy1;
    logic              busy2;
    ooo_pkg::tag_t     tag1;
    ooo_pkg::tag_t     tag2;
    logic              q1_done;
    logic              q2_done;
    ooo_pkg::data_t    q1_value;
    ooo_pkg::data_t    q2_value;

    // stores never own a register
    assign accept_rd = alloc.is_store ? '0 : alloc.rd;

    arch_regfile u_regfile (
        .clk    (clk),
        .rst    (rst),
        .commit (commit),
        .rs1    (rs1),
        .rs2    (rs2),
        .rd1    (rf1),
        .rd2    (rf2)
    );

    rename_table u_rename (
        .clk        (clk),
        .rst        (rst),
        .accept     (accept),
        .accept_rd  (accept_rd),
        .accept_tag (alloc_tag),
        .commit     (commit),
        .flush      (flush),
        .rs1        (rs1),
        .rs2        (rs2),
        .busy1      (busy1),
        .busy2      (busy2),
        .tag1       (tag1),
        .tag2       (tag2)
    );

    reorder_buffer u_rob (
        .clk           (clk),
        .rst           (rst),
        .alloc         (alloc),
        .alloc_tag     (alloc_tag),
        .alloc_full    (alloc_full),
        .accept        (accept),
        .wb            (wb),
        .store_ack     (store_ack),
        .store_ack_tag (store_ack_tag),
        .store_rel     (store_rel),
        .commit        (commit),
        .redirect      (redirect),
        .flush         (flush),
        .q1_tag        (tag1),
        .q2_tag        (tag2),
        .q1_done       (q1_done),
        .q2_done       (q2_done),
        .q1_value      (q1_value),
        .q2_value      (q2_value)
    );

    operand_resolve u_op1 (
        .busy      (busy1),
        .tag       (tag1),
        .rf_value  (rf1),
        .rob_done  (q1_done),
        .rob_value (q1_value),
        .op        (op1)
    );

    operand_resolve u_op2 (
        .busy      (busy2),
        .tag       (tag2),
        .rf_value  (rf2),
        .rob_done  (q2_done),
        .rob_value (q2_value),
        .op        (op2)
    );

endmodule

// File: dv/ooo_backend_assert.sv
module ooo_backend_assert (
    input logic                clk,
    input logic                rst,
    input ooo_pkg::alloc_req_t alloc,
    input ooo_pkg::tag_t       alloc_tag,
    input logic                alloc_full,
    input logic                flush,
    input ooo_pkg::commit_t    commit,
    input ooo_pkg::store_rel_t store_rel,
    input ooo_pkg::redirect_t  redirect
);

    logic [ooo_pkg::rob_depth-1:0] released; // store released, commit pending
    int                            fail_count = 0;

    always_ff @(posedge clk) begin
        if (rst || redirect.valid) begin
            released <= '0;
        end else begin
            if (commit.valid) begin
                released[commit.tag] <= 1'b0;
            end
            if (store_rel.valid) begin
                released[store_rel.tag] <= 1'b1;
            end
        end
    end

    a_reset_quiet: assert property (@(posedge clk)
        rst |=> !commit.valid && !store_rel.valid && !redirect.valid)
        else begin
            fail_count++;
            $error("commit, store release or redirect active during reset");
        end

    // the flush edge also empties the buffer
    a_redirect_commit: assert property (@(posedge clk) disable iff (rst)
        redirect.valid |-> commit.valid && alloc_tag == '0 && !alloc_full)
        else begin
            fail_count++;
            $error("redirect without a commit, or with entries left in the buffer");
        end

    a_full_hold: assert property (@(posedge clk) disable iff (rst)
        alloc.valid && alloc_full && !flush |=> $stable(alloc_tag))
        else begin
            fail_count++;
            $error("allocation while full moved the tail");
        end

    a_single_release: assert property (@(posedge clk) disable iff (rst)
        store_rel.valid |-> !released[store_rel.tag])
        else begin
            fail_count++;
            $error("store released twice before its commit");
        end

endmodule

bind reorder_buffer ooo_backend_assert u_assert (
    .clk        (clk),
    .rst        (rst),
    .alloc      (alloc),
    .alloc_tag  (alloc_tag),
    .alloc_full (alloc_full),
    .flush      (flush),
    .commit     (commit),
    .store_rel  (store_rel),
    .redirect   (redirect)
);

// File: dv/tb_ooo_backend.sv
module tb_ooo_backend;

    localparam int max_cycles = 2000; // tests need about 600

    typedef struct packed {
        ooo_pkg::reg_idx_t rd;
        ooo_pkg::tag_t     tag;
        ooo_pkg::data_t    data;
        logic              redir;
        ooo_pkg::addr_t    pc;
    } exp_t;

    logic                clk;
    logic                rst;
    ooo_pkg::alloc_req_t alloc;
    ooo_pkg::reg_idx_t   rs1;
    ooo_pkg::reg_idx_t   rs2;
    ooo_pkg::wb_t        wb;
    logic                store_ack;
    ooo_pkg::tag_t       store_ack_tag;
    ooo_pkg::tag_t       alloc_tag;
    logic                alloc_full;
    ooo_pkg::operand_t   op1;
    ooo_pkg::operand_t   op2;
    ooo_pkg::commit_t    commit;
    ooo_pkg::store_rel_t store_rel;
    ooo_pkg::redirect_t  redirect;

    exp_t              exp_q [$];
    ooo_pkg::data_t    ref_rf [ooo_pkg::reg_count]; // committed state in program order
    ooo_pkg::reg_idx_t pend_rd [ooo_pkg::rob_depth];
    ooo_pkg::data_t    pend_data [ooo_pkg::rob_depth];
    ooo_pkg::tag_t     batch [$];
    logic [31:0]       rng_state;
    int                rel_count;
    ooo_pkg::tag_t     rel_tag;
    int                cycles;

    ooo_backend DUT (
        .clk           (clk),
        .rst           (rst),
        .alloc         (alloc),
        .rs1           (rs1),
        .rs2           (rs2),
        .wb            (wb),
        .store_ack     (store_ack),
        .store_ack_tag (store_ack_tag),
        .alloc_tag     (alloc_tag),
        .alloc_full    (alloc_full),
        .op1           (op1),
        .op2           (op2),
        .commit        (commit),
        .store_rel     (store_rel),
        .redirect      (redirect)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    task automatic stop_fail();
        $display("Verification failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("MISMATCH %s got 0x%0h expected 0x%0h", name, got, exp);
            stop_fail();
        end
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles >= max_cycles) begin
            $display("timeout: the tests did not finish within %0d cycles", max_cycles);
            stop_fail();
        end
    end

    // commit and store release monitor
    always @(negedge clk) begin
        exp_t e;
        if (!rst) begin
            if (store_rel.valid) begin
                rel_count++;
                rel_tag = store_rel.tag;
            end
            if (DUT.u_rob.u_assert.fail_count != 0) begin
                $display("a protocol assertion on the reorder buffer failed");
                stop_fail();
            end else if (redirect.valid && !commit.valid) begin
                $display("redirect raised in a cycle without a commit");
                stop_fail();
            end else if (commit.valid) begin
                if (exp_q.size() == 0) begin
                    $display("unexpected commit of tag %0d", commit.tag);
                    stop_fail();
                end else begin
                    e = exp_q.pop_front();
                    check("commit.tag", commit.tag, e.tag);
                    check("commit.rd", commit.rd, e.rd);
                    check("commit.data", commit.data, e.data);
                    check("redirect.valid", redirect.valid, e.redir);
                    if (e.redir) begin
                        check("redirect.pc", redirect.pc, e.pc);
                    end
                    if (e.rd != '0) begin
                        ref_rf[e.rd] = e.data;
                    end
                end
            end
        end
    end

    // one cycle per call, pulses last a single edge
    task automatic step();
        @(negedge clk);
        alloc.valid = 1'b0;
        wb.valid    = 1'b0;
        store_ack   = 1'b0;
    endtask

    task automatic drive_alloc(input ooo_pkg::reg_idx_t rd, input logic is_store,
                               input logic pred, output ooo_pkg::tag_t tag);
        check("alloc_full", alloc_full, 1'b0);
        tag             = alloc_tag;
        pend_rd[tag]    = is_store ? '0 : rd;
        pend_data[tag]  = is_store ? '0 : next_rand();
        alloc.valid      = 1'b1;
        alloc.rd         = rd;
        alloc.is_store   = is_store;
        alloc.pred_taken = pred;
    endtask

    task automatic expect_commit(input ooo_pkg::tag_t tag, input logic redir,
                                 input ooo_pkg::addr_t pc);
        exp_t e;
        e.rd    = pend_rd[tag];
        e.tag   = tag;
        e.data  = pend_data[tag];
        e.redir = redir;
        e.pc    = pc;
        exp_q.push_back(e);
    endtask

    task automatic alloc_plain(input ooo_pkg::reg_idx_t rd, output ooo_pkg::tag_t tag);
        step();
        drive_alloc(rd, 1'b0, 1'b0, tag);
        expect_commit(tag, 1'b0, '0);
    endtask

    task automatic drive_wb(input ooo_pkg::tag_t tag, input logic taken,
                            input ooo_pkg::addr_t target);
        wb.valid  = 1'b1;
        wb.tag    = tag;
        wb.data   = pend_data[tag];
        wb.taken  = taken;
        wb.target = target;
    endtask

    task automatic write_back(input ooo_pkg::tag_t tag, input logic taken,
                              input ooo_pkg::addr_t target);
        step();
        drive_wb(tag, taken, target);
    endtask

    task automatic wait_commits(input int left);
        step();
        while (exp_q.size() > left) begin
            @(posedge clk);
        end
        step();
    endtask

    task automatic lookup(input ooo_pkg::reg_idx_t r1, input ooo_pkg::reg_idx_t r2);
        step();
        rs1 = r1;
        rs2 = r2;
        #25; // settle before the next edge
    endtask

    task automatic check_reg(input ooo_pkg::reg_idx_t r);
        lookup(r, r);
        check($sformatf("op1.ready x%0d", r), op1.ready, 1'b1);
        check($sformatf("op1.value x%0d", r), op1.value, ref_rf[r]);
        check($sformatf("op2.ready x%0d", r), op2.ready, 1'b1);
        check($sformatf("op2.value x%0d", r), op2.value, ref_rf[r]);
    endtask

    task automatic fill_buffer();
        ooo_pkg::tag_t t;
        batch.delete();
        repeat (ooo_pkg::rob_depth) begin
            alloc_plain(ooo_pkg::reg_idx_t'(next_rand()), t);
            batch.push_back(t);
        end
        step();
        check("alloc_full", alloc_full, 1'b1);
    endtask

    task automatic drain_batch(input int lo);
        for (int i = batch.size() - 1; i >= lo; i--) begin
            write_back(batch[i], 1'b0, '0);
        end
        wait_commits(0);
    endtask

    task automatic test_in_order();
        ooo_pkg::tag_t tags [5];
        int            order [5] = '{3, 0, 4, 1, 2};
        for (int i = 0; i < 5; i++) begin
            alloc_plain(ooo_pkg::reg_idx_t'(i + 1), tags[i]);
            check("alloc_tag", tags[i], i);
        end
        foreach (order[i]) begin
            write_back(tags[order[i]], 1'b0, '0);
        end
        wait_commits(0);
        for (int i = 0; i < 5; i++) begin
            check_reg(ooo_pkg::reg_idx_t'(i + 1));
            check("op1.value", op1.value, pend_data[tags[i]]);
        end
    endtask

    task automatic test_operands();
        ooo_pkg::tag_t t_old;
        ooo_pkg::tag_t t_new;
        alloc_plain(7, t_old);
        lookup(7, 7);
        check("op1.ready", op1.ready, 1'b0);
        check("op1.tag", op1.tag, t_old);
        check("op2.ready", op2.ready, 1'b0);
        check("op2.tag", op2.tag, t_old);
        write_back(t_old, 1'b0, '0);
        lookup(7, 0); // done but not yet committed
        check("op1.ready", op1.ready, 1'b1);
        check("op1.value", op1.value, pend_data[t_old]);
        wait_commits(0);
        check_reg(7);
        alloc_plain(7, t_old);
        alloc_plain(7, t_new);
        lookup(7, 0);
        check("op1.tag", op1.tag, t_new);
        write_back(t_old, 1'b0, '0);
        wait_commits(1);
        lookup(7, 0);
        check("op1.ready", op1.ready, 1'b0);
        check("op1.tag", op1.tag, t_new);
        write_back(t_new, 1'b0, '0);
        wait_commits(0);
        check_reg(7);
    endtask

    task automatic test_full();
        ooo_pkg::tag_t t_full;
        fill_buffer();
        t_full = alloc_tag;
        alloc.valid = 1'b1; // 17th, must be ignored
        alloc.rd    = 5'd5;
        step();
        check("alloc_full", alloc_full, 1'b1);
        check("alloc_tag", alloc_tag, t_full);
        write_back(batch[0], 1'b0, '0);
        wait_commits(ooo_pkg::rob_depth - 1);
        check("alloc_full", alloc_full, 1'b0);
        drain_batch(1);
    endtask

    task automatic test_stores();
        ooo_pkg::tag_t ta;
        ooo_pkg::tag_t ts;
        int            rel0;
        alloc_plain(12, ta);
        step();
        drive_alloc(9, 1'b1, 1'b0, ts);
        expect_commit(ts, 1'b0, '0);
        rel0 = rel_count;
        repeat (4) step();
        @(posedge clk);
        check("store_rel count", rel_count, rel0);
        write_back(ta, 1'b0, '0);
        wait_commits(1);
        while (rel_count < rel0 + 1) begin
            @(posedge clk);
        end
        check("store_rel.tag", rel_tag, ts);
        repeat (4) step();
        @(posedge clk);
        check("store_rel count", rel_count, rel0 + 1);
        step();
        store_ack     = 1'b1;
        store_ack_tag = ts;
        wait_commits(0);
        check_reg(9);
        check_reg(12);
    endtask

    task automatic test_mispredict();
        ooo_pkg::tag_t  tbr;
        ooo_pkg::tag_t  young [3];
        ooo_pkg::addr_t target;
        target = next_rand();
        step();
        drive_alloc(20, 1'b0, 1'b0, tbr);
        expect_commit(tbr, 1'b1, target);
        for (int i = 0; i < 3; i++) begin
            step();
            drive_alloc(ooo_pkg::reg_idx_t'(21 + i), 1'b0, 1'b0, young[i]);
        end
        for (int i = 0; i < 3; i++) begin
            write_back(young[i], 1'b0, '0);
        end
        write_back(tbr, 1'b1, target);
        wait_commits(0);
        repeat (4) step(); // younger commits would reach the monitor here
        check_reg(20);
        for (int i = 0; i < 3; i++) begin
            check_reg(ooo_pkg::reg_idx_t'(21 + i));
        end
        fill_buffer();
        drain_batch(0);
    endtask

    task automatic test_random();
        ooo_pkg::tag_t t;
        ooo_pkg::tag_t pend [$];
        logic [31:0]   r;
        int            k;
        for (int c = 0; c < 300; c++) begin
            step();
            r = next_rand();
            // completion before allocation, never for the entry entering now
            if (r[1] && pend.size() != 0) begin
                k = int'(r[31:16]) % pend.size();
                t = pend[k];
                pend.delete(k);
                drive_wb(t, 1'b0, '0);
            end
            if (r[3:2] != 2'b00 && !alloc_full) begin
                drive_alloc(ooo_pkg::reg_idx_t'(r[12:8]), 1'b0, 1'b0, t);
                expect_commit(t, 1'b0, '0);
                pend.push_back(t);
            end
        end
        while (pend.size() != 0) begin
            t = pend.pop_front();
            write_back(t, 1'b0, '0);
        end
        wait_commits(0);
        for (int i = 1; i < ooo_pkg::reg_count; i++) begin
            check_reg(ooo_pkg::reg_idx_t'(i));
        end
    endtask

    initial begin
        clk           = 1'b0;
        rst           = 1'b1;
        alloc         = '0;
        rs1           = '0;
        rs2           = '0;
        wb            = '0;
        store_ack     = 1'b0;
        store_ack_tag = '0;
        rng_state     = 32'h2d8b_2148;
        rel_count     = 0;
        cycles        = 0;
        for (int i = 0; i < ooo_pkg::reg_count; i++) begin
            ref_rf[i] = '0;
        end
        repeat (8) @(negedge clk);
        rst = 1'b0;
        check("alloc_full", alloc_full, 1'b0);
        check("alloc_tag", alloc_tag, 0);
        check("commit.valid", commit.valid, 1'b0);
        check("store_rel.valid", store_rel.valid, 1'b0);
        check("redirect.valid", redirect.valid, 1'b0);
        test_in_order();
        test_operands();
        test_full();
        test_stores();
        test_mispredict();
        test_random();
        $display("Verification passed");
        $finish;
    end

endmodule

// File: src.f
source/ooo_pkg.sv
source/arch_regfile.sv
source/rename_table.sv
source/reorder_buffer.sv
source/operand_resolve.sv
source/ooo_backend.sv
dv/ooo_backend_assert.sv
dv/tb_ooo_backend.sv
